// File: arrayDirectory.sv
/*
 * Array directory of the heap: allocation flags, sizes, free stack and fresh count.
 * Registers the error check for each command and applies bookkeeping on commit.
 */
`timescale 1ns/1ps

module arrayDirectory #(
  parameter int heapArrays  = 2 ** heapPkg::addressBits,  // Usable arrays
  parameter int arrayLength = 2 ** heapPkg::indexBits     // Elements per array
) (
  input  logic                     clock,
  input  logic                     reset,
  input  heapPkg::directoryCommand command,
  input  logic                     commit,                // Apply command this edge
  output heapPkg::directoryStatus  status
);
  import heapPkg::*;

  localparam int slots = 2 ** addressBits;                // Whole array number space

  typedef logic [addressBits:0] arrayCount;               // Holds 0 .. slots

  logic      allocated [slots];                           // Live flag per array
  heapSize   sizes     [slots];
  arrayId    freeStack [slots];                           // Freed arrays, LIFO
  arrayCount freeTop;                                     // Entries on free stack
  arrayCount freshCount;                                  // Arrays ever handed out

  heapSize  currentSize;
  arrayId   choice;
  heapError check;
  logic     readsElement;

  assign currentSize  = sizes[command.array];
  assign readsElement = command.op inside {opRead, opAdd, opSubtract, opOr, opXor, opAnd};

  // Reuse newest freed array, else next fresh one
  assign choice = (freeTop != '0) ? freeStack[arrayId'(freeTop - 1'b1)]
                                  : arrayId'(freshCount);

  // ----------------------------------------------------------
  // Error check in priority order
  // ----------------------------------------------------------
  always_comb begin
    check = errNone;
    if (command.op == opAlloc) begin
      if (freeTop == '0 && freshCount >= arrayCount'(heapArrays)) begin
        check = errOutOfMemory;                           // Nothing freed, nothing fresh
      end
    end else if (command.op != opReset) begin
      if ({1'b0, command.array} >= freshCount) begin
        check = errNotAllocated;
      end else if (!allocated[command.array]) begin
        check = errFreed;                                 // Also catches double free
      end else if (readsElement && {1'b0, command.index} >= currentSize) begin
        check = errOutOfBounds;
      end else if (command.op == opWrite && int'(command.index) >= arrayLength) begin
        check = errOutOfBounds;
      end else if (command.op == opPush && int'(currentSize) >= arrayLength) begin
        check = errFull;
      end else if (command.op == opPop && currentSize == '0) begin
        check = errEmpty;
      end
    end
  end

  always_ff @(posedge clock) begin
    status.error      <= check;                           // Valid one cycle after command
    status.size       <= currentSize;
    status.allocArray <= choice;
  end

  // ----------------------------------------------------------
  // Bookkeeping on commit
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      freeTop    <= '0;
      freshCount <= '0;
      for (int i = 0; i < slots; i++) begin
        allocated[i] <= 1'b0;
      end
    end else if (commit) begin
      case (command.op)
        opReset: begin
          freeTop    <= '0;                               // Forget every array
          freshCount <= '0;
          for (int i = 0; i < slots; i++) begin
            allocated[i] <= 1'b0;
          end
        end
        opAlloc: begin
          allocated[choice] <= 1'b1;
          if (freeTop != '0) begin
            freeTop <= freeTop - 1'b1;                    // Pop free stack
          end else begin
            freshCount <= freshCount + 1'b1;
          end
        end
        opFree: begin
          allocated[command.array] <= 1'b0;
          freeTop                  <= freeTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (commit) begin
      case (command.op)
        opAlloc: sizes[choice] <= '0;                     // New array starts empty
        opFree:  freeStack[arrayId'(freeTop)] <= command.array;
        opWrite: begin
          if ({1'b0, command.index} >= currentSize) begin
            sizes[command.array] <= {1'b0, command.index} + 1'b1;  // Grow to index+1
          end
        end
        opPush:  sizes[command.array] <= currentSize + 1'b1;
        opPop:   sizes[command.array] <= currentSize - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: compile.f
heapPkg.sv
arrayDirectory.sv
elementStore.sv
heapSequencer.sv
heapTop.sv
tbClock.sv
heapTb.sv

// File: elementStore.sv
/*
 * Element memory of the heap, one fixed block of arrayLength words per array.
 * One registered read port and one write port.
 */
`timescale 1ns/1ps

module elementStore #(
  parameter int heapArrays  = 2 ** heapPkg::addressBits,  // Arrays held
  parameter int arrayLength = 2 ** heapPkg::indexBits     // Words per array
) (
  input  logic                 clock,
  input  heapPkg::arrayId      readArray,
  input  heapPkg::elementIndex readIndex,
  output heapPkg::element      readData,                  // One cycle after address
  input  logic                 writeEnable,
  input  heapPkg::arrayId      writeArray,
  input  heapPkg::elementIndex writeIndex,
  input  heapPkg::element      writeData
);
  import heapPkg::*;

  localparam int depth    = heapArrays * arrayLength;
  localparam int slotBits = $clog2(depth);

  element memory [depth];                                 // Contents not reset

  logic [slotBits-1:0] readSlot;
  logic [slotBits-1:0] writeSlot;

  // Flat word address, array block plus offset
  assign readSlot  = slotBits'(readArray * arrayLength + readIndex);
  assign writeSlot = slotBits'(writeArray * arrayLength + writeIndex);

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[writeSlot] <= writeData;
    end
    readData <= memory[readSlot];                         // Old word on same-edge write
  end

endmodule

// File: heapPkg.sv
/*
 * Shared widths, opcode and error encodings, and the bus structs of the array heap.
 * Imported by every heap module and by the testbench.
 */
package heapPkg;

  // ----------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------
  localparam int addressBits = 3;                   // Array number width
  localparam int indexBits   = 3;                   // Element index width
  localparam int dataBits    = 16;                  // Element width

  typedef logic [addressBits-1:0] arrayId;          // Array number
  typedef logic [indexBits-1:0]   elementIndex;     // Index within an array
  typedef logic [dataBits-1:0]    element;          // One stored word
  typedef logic [indexBits:0]     heapSize;         // Size, 0 .. full length

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    opReset    = 4'd0,                              // Clear the directory
    opAlloc    = 4'd1,                              // Take a freed or fresh array
    opFree     = 4'd2,                              // Return array for reuse
    opSize     = 4'd3,                              // Current size
    opWrite    = 4'd4,                              // Store, growing if past end
    opRead     = 4'd5,
    opPush     = 4'd6,
    opPop      = 4'd7,
    opAdd      = 4'd8,                              // Element arithmetic, new value out
    opSubtract = 4'd9,
    opOr       = 4'd10,
    opXor      = 4'd11,
    opAnd      = 4'd12
  } heapOp;

  // Listed in check priority, first failing check is reported
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                         // Array at or above fresh count
    errFreed        = 3'd2,                         // Array currently on free stack
    errOutOfBounds  = 3'd3,                         // Index past size or length
    errFull         = 3'd4,                         // Push onto full array
    errEmpty        = 3'd5,                         // Pop from empty array
    errOutOfMemory  = 3'd6                          // No array left for Alloc
  } heapError;

  // ----------------------------------------------------------
  // Bus and internal structs
  // ----------------------------------------------------------
  typedef struct packed {
    heapOp       op;
    arrayId      array;
    elementIndex index;
    element      data;
  } heapRequest;                                    // Command from the master

  typedef struct packed {
    heapError error;
    element   data;
  } heapResponse;                                   // Result back to the master

  typedef struct packed {
    heapOp       op;
    arrayId      array;
    elementIndex index;
  } directoryCommand;                               // Sequencer to directory

  typedef struct packed {
    heapError error;                                // Registered check result
    heapSize  size;                                 // Size of addressed array
    arrayId   allocArray;                           // Array Alloc would hand out
  } directoryStatus;                                // Directory to sequencer

endpackage

// File: heapSequencer.sv
/*
 * Wishbone classic slave and command FSM of the heap.
 * Looks up the directory and store, executes the command, then acknowledges.
 */
`timescale 1ns/1ps

module heapSequencer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     cycle,                 // Wishbone CYC
  input  logic                     strobe,                // Wishbone STB
  input  heapPkg::heapRequest      request,
  output logic                     acknowledge,           // Wishbone ACK, one cycle
  output heapPkg::heapResponse     response,
  output heapPkg::directoryCommand command,
  output logic                     commit,
  input  heapPkg::directoryStatus  status,
  output heapPkg::arrayId          readArray,
  output heapPkg::elementIndex     readIndex,
  output logic                     writeEnable,
  output heapPkg::arrayId          writeArray,
  output heapPkg::elementIndex     writeIndex,
  output heapPkg::element          writeData,
  input  heapPkg::element          readData
);
  import heapPkg::*;

  typedef enum logic [1:0] {
    idle,                                                 // Waiting for CYC and STB
    lookup,                                               // Check and element available
    execute,                                              // Store and directory updated
    respond                                               // ACK high
  } sequencerState;

  sequencerState state;
  heapRequest    held;                                    // Latched command
  heapRequest    current;
  heapError      heldError;
  element        heldData;
  element        computed;                                // Arithmetic result
  element        word;                                    // Data word for response
  logic          accept;
  logic          noError;
  logic          arithmetic;
  logic          popping;

  assign accept     = state == idle && cycle && strobe;
  assign current    = (state == idle) ? request : held;   // Bus request feeds edge 1
  assign noError    = status.error == errNone;
  assign arithmetic = held.op inside {opAdd, opSubtract, opOr, opXor, opAnd};
  assign popping    = held.op == opPop && heldError == errNone;

  // ----------------------------------------------------------
  // Directory and store addressing
  // ----------------------------------------------------------
  assign command = '{op: current.op, array: current.array, index: current.index};
  assign commit  = state == lookup && noError;

  assign readArray = current.array;
  assign readIndex = (state == lookup && held.op == opPop)
                     ? elementIndex'(status.size - 1'b1)  // Top element, read at edge 2
                     : current.index;

  assign writeEnable = state == lookup && noError
                       && (held.op inside {opWrite, opPush} || arithmetic);
  assign writeArray  = held.array;
  assign writeIndex  = (held.op == opPush) ? elementIndex'(status.size) : held.index;
  assign writeData   = arithmetic ? computed : held.data;

  always_comb begin
    case (held.op)
      opAdd:      computed = readData + held.data;
      opSubtract: computed = readData - held.data;
      opOr:       computed = readData | held.data;
      opXor:      computed = readData ^ held.data;
      opAnd:      computed = readData & held.data;
      default:    computed = readData;
    endcase
  end

  // Zero unless the check passed
  always_comb begin
    word = '0;
    if (noError) begin
      case (held.op)
        opAlloc:         word = element'(status.allocArray);
        opSize:          word = element'(status.size);
        opRead:          word = readData;
        opWrite, opPush: word = held.data;                // Echo written value
        opAdd, opSubtract, opOr, opXor, opAnd: begin
          word = computed;
        end
        default:         word = '0;                       // Free, Reset, Pop later
      endcase
    end
  end

  // ----------------------------------------------------------
  // FSM and response
  // ----------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (accept) state <= lookup;
        lookup:  state <= execute;
        execute: state <= respond;
        respond: state <= idle;                           // Next command one edge later
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held <= request;
    end
    if (state == lookup) begin
      heldError <= status.error;
      heldData  <= word;
    end
    if (state == execute) begin
      response.error <= heldError;
      response.data  <= popping ? readData : heldData;    // Pop word arrives now
    end
  end

  assign acknowledge = state == respond;

endmodule

// File: heapTb.sv
/*
 * Testbench of the array heap. Reads heapTests.txt, drives one Wishbone command per
 * line and checks the error code, the data word and the acknowledge timing.
 */
`timescale 1ns/1ps

module heapTb;
  import heapPkg::*;

  localparam int maxTests   = 64;
  localparam int ackLatency = 3;                          // Accepting edge to ACK sample

  logic        clock;
  logic        reset;
  logic        cycle;
  logic        strobe;
  logic        acknowledge;
  heapRequest  request;
  heapResponse response;

  logic [47:0] tests [maxTests];                          // op array index data err expected
  int          testCount;
  int          passCount;
  int          failCount;
  int          checkErrors;                               // Every failing check
  bit          loaded;

  tbClock clocks (
    .clock (clock),
    .reset (reset)
  );

  heapTop #(.heapArrays(4), .arrayLength(4)) dut (
    .clock       (clock),
    .reset       (reset),
    .cycle       (cycle),
    .strobe      (strobe),
    .request     (request),
    .acknowledge (acknowledge),
    .response    (response)
  );

  // ----------------------------------------------------------
  // Watchdog, 8 cycles per test plus setup margin
  // ----------------------------------------------------------
  initial begin
    wait (loaded);
    repeat (testCount * 8 + 100) @(posedge clock);
    $display("Run timed out after %0d cycles before all tests finished", testCount * 8 + 100);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic loadTests;
    for (int i = 0; i < maxTests; i++) begin
      tests[i] = {4'hf, 44'(i)};                          // Opcode f marks unused entry
    end
    $readmemh("heapTests.txt", tests);
    testCount = 0;
    while (testCount < maxTests && tests[testCount][47:44] != 4'hf) begin
      testCount++;
    end
  endtask

  task automatic checkAckLow(input string phase);
    if (acknowledge) begin
      $display("acknowledge was high %s at %0t", phase, $time);
      checkErrors++;
    end
  endtask

  // One command, from drive to checked response
  task automatic runTest(input int n);
    logic [47:0] entry;
    heapOp       op;
    heapError    expError;
    heapError    gotError;
    element      expData;
    int          waited;
    bit          ok;
    entry    = tests[n];
    op       = heapOp'(entry[47:44]);
    expError = heapError'(entry[18:16]);
    expData  = entry[15:0];
    waited   = 0;
    ok       = 1'b1;
    @(posedge clock);
    cycle   <= 1'b1;
    strobe  <= 1'b1;
    request <= '{op: op, array: entry[42:40], index: entry[38:36], data: entry[35:20]};
    // First negedge is before the accepting edge
    do begin
      @(negedge clock);
      waited++;
    end while (!acknowledge && waited <= ackLatency + 8);
    if (!acknowledge) begin
      $display("test %0d: no acknowledge within %0d cycles", n, waited);
      ok = 1'b0;
      checkErrors++;
    end else begin
      gotError = response.error;
      if (waited - 1 != ackLatency) begin
        $display("MISMATCH at %0t: acknowledge latency expected %0d got %0d",
                 $time, ackLatency, waited - 1);
        ok = 1'b0;
        checkErrors++;
      end
      if (gotError != expError) begin
        $display("MISMATCH at %0t: response.error expected %s got %s",
                 $time, expError.name(), gotError.name());
        ok = 1'b0;
        checkErrors++;
      end
      if (response.data != expData) begin
        $display("MISMATCH at %0t: response.data expected %h got %h",
                 $time, expData, response.data);
        ok = 1'b0;
        checkErrors++;
      end
    end
    if (ok) begin
      passCount++;
    end else begin
      failCount++;
    end
    $display("test %0d %s array %0d index %0d: %s", n, op.name(), entry[42:40], entry[38:36],
             ok ? "ok" : "FAILED");
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int gap;
    cycle   <= 1'b0;                                      // Bus idle from time zero
    strobe  <= 1'b0;
    request <= '0;
    loadTests();
    loaded = 1'b1;
    if (testCount == 0) begin
      $display("No tests found in heapTests.txt");
      checkErrors++;
    end
    while (reset !== 1'b1) begin
      @(negedge clock);
      checkAckLow("during reset");
    end
    repeat (3) begin
      @(negedge clock);
      checkAckLow("before the first command");
    end
    for (int n = 0; n < testCount; n++) begin
      gap = n % 3;                                        // 0 means back to back
      if (gap > 0) begin
        @(posedge clock);
        cycle  <= 1'b0;
        strobe <= 1'b0;
        repeat (gap) begin
          @(negedge clock);
          checkAckLow("between commands");
        end
      end
      runTest(n);
    end
    @(posedge clock);
    cycle  <= 1'b0;
    strobe <= 1'b0;
    @(negedge clock);
    checkAckLow("after the last acknowledge");
    $display("%0d tests, %0d passed, %0d failed, %0d failing checks",
             testCount, passCount, failCount, checkErrors);
    if (checkErrors == 0 && failCount == 0 && testCount > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: heapTests.txt
// Hex fields: op _ array _ index _ data _ expected error _ expected data
// Ops 0 Reset 1 Alloc 2 Free 3 Size 4 Write 5 Read 6 Push 7 Pop 8..c Add Sub Or Xor And
3_0_0_0000_1_0000 // Size before any Alloc, not allocated
1_0_0_0000_0_0000 // Fresh arrays 0, 1, 2
1_0_0_0000_0_0001
1_0_0_0000_0_0002
2_1_0_0000_0_0000 // Free 1 then 0
2_0_0_0000_0_0000
1_0_0_0000_0_0000 // Reuse last freed first
1_0_0_0000_0_0001
1_0_0_0000_0_0003 // Last fresh array
1_0_0_0000_6_0000 // Out of memory
4_0_2_1234_0_1234 // Write past end grows size to 3
3_0_0_0000_0_0003
4_0_0_00a5_0_00a5
5_0_2_0000_0_1234
5_0_0_0000_0_00a5
5_0_3_0000_3_0000 // Read at size
4_0_5_9999_3_0000 // Write beyond array length
3_0_0_0000_0_0003 // Size unchanged after errors
7_1_0_0000_5_0000 // Pop from empty
6_1_0_1111_0_1111
6_1_0_2222_0_2222
6_1_0_3333_0_3333
6_1_0_4444_0_4444
6_1_0_5555_4_0000 // Push onto full
3_1_0_0000_0_0004
7_1_0_0000_0_4444 // LIFO order
7_1_0_0000_0_3333
7_1_0_0000_0_2222
7_1_0_0000_0_1111
7_1_0_0000_5_0000
4_2_0_0f0f_0_0f0f
8_2_0_0101_0_1010 // Add
9_2_0_0010_0_1000 // Subtract
a_2_0_00ff_0_10ff // Or
b_2_0_1f0f_0_0ff0 // Xor
c_2_0_0f3c_0_0f30 // And
5_2_0_0000_0_0f30
8_2_1_0001_3_0000 // Arithmetic at size
2_3_0_0000_0_0000
5_3_0_0000_2_0000 // Access to freed array
2_3_0_0000_2_0000 // Double free
1_0_0_0000_0_0003
1_0_0_0000_6_0000 // Free stack not corrupted
3_5_0_0000_1_0000 // Above fresh count
0_0_0_0000_0_0000 // Reset command
3_0_0_0000_1_0000
1_0_0_0000_0_0000
3_0_0_0000_0_0000
f_0_0_0000_0_0000 // End of tests

// File: heapTop.sv
/*
 * Top level of the array heap, a Wishbone classic slave.
 * Connects the sequencer to the array directory and the element store.
 */
`timescale 1ns/1ps

module heapTop #(
  parameter int heapArrays  = 2 ** heapPkg::addressBits,  // Usable arrays
  parameter int arrayLength = 2 ** heapPkg::indexBits     // Elements per array
) (
  input  logic                 clock,
  input  logic                 reset,                     // Active low, async
  input  logic                 cycle,
  input  logic                 strobe,
  input  heapPkg::heapRequest  request,
  output logic                 acknowledge,
  output heapPkg::heapResponse response
);
  import heapPkg::*;

  directoryCommand command;
  directoryStatus  status;
  logic            commit;
  arrayId          readArray;
  elementIndex     readIndex;
  element          readData;
  logic            writeEnable;
  arrayId          writeArray;
  elementIndex     writeIndex;
  element          writeData;

  heapSequencer sequencer (
    .clock       (clock),
    .reset       (reset),
    .cycle       (cycle),
    .strobe      (strobe),
    .request     (request),
    .acknowledge (acknowledge),
    .response    (response),
    .command     (command),
    .commit      (commit),
    .status      (status),
    .readArray   (readArray),
    .readIndex   (readIndex),
    .writeEnable (writeEnable),
    .writeArray  (writeArray),
    .writeIndex  (writeIndex),
    .writeData   (writeData),
    .readData    (readData)
  );

  arrayDirectory #(.heapArrays(heapArrays), .arrayLength(arrayLength)) directory (
    .clock   (clock),
    .reset   (reset),
    .command (command),
    .commit  (commit),
    .status  (status)
  );

  elementStore #(.heapArrays(heapArrays), .arrayLength(arrayLength)) store (
    .clock       (clock),
    .readArray   (readArray),
    .readIndex   (readIndex),
    .readData    (readData),
    .writeEnable (writeEnable),
    .writeArray  (writeArray),
    .writeIndex  (writeIndex),
    .writeData   (writeData)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the heap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module heapTb

output="$(./obj_dir/VheapTb)"
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

// File: tbClock.sv
/*
 * Testbench clock and reset source for the heap.
 * 10 ns clock, active low reset held for the first resetCycles rising edges.
 */
`timescale 1ns/1ps

module tbClock #(
  parameter int resetCycles = 10                          // Edges with reset low
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;                            // 100 MHz
  end

  initial begin
    reset <= 1'b0;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b1;                                        // Release on a rising edge
  end

endmodule
